// File: design/systolic_config.svh
`ifndef SYSTOLIC_CONFIG_SVH
`define SYSTOLIC_CONFIG_SVH

////////////////////
// Array geometry
////////////////////

// Rows and columns of the PE mesh
`define SYS_SIZE 4
`define SYS_DWIDTH 8
`define SYS_AWIDTH 10
`define SYS_STRIDE_WIDTH 8
`define SYS_CNT_WIDTH 8

////////////////////
// Pipeline timing
////////////////////

`define SYS_MAC_STAGES 3
`define SYS_MEM_LATENCY 1

// Count at which every accumulator holds its final sum
// Skew fill, operand stream and drain of the mesh take 3*N-1 counts, then the MAC pipeline
`define SYS_CAPTURE_CYCLE ((3 * `SYS_SIZE) - 1 + `SYS_MAC_STAGES)

`endif

// File: design/systolic_pkg.sv
`include "systolic_config.svh"

package systolic_pkg;

    // One matrix element
    typedef logic [`SYS_DWIDTH-1:0] data_t;

    typedef logic [`SYS_AWIDTH-1:0] addr_t;
    typedef logic [`SYS_STRIDE_WIDTH-1:0] stride_t;
    typedef logic [`SYS_CNT_WIDTH-1:0] cycle_t;

    // One memory word, lane 0 in the low byte
    // Holds a column of A, a row of B or a column of C
    typedef data_t [`SYS_SIZE-1:0] data_vec_t;

    // Placement of one matrix in its memory
    typedef struct packed {
        addr_t   base;
        stride_t stride;
    } mat_region_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_FINISHED
    } seq_state_t;

endpackage

// File: design/mac_pe.sv
`timescale 1ns/100ps
`include "systolic_config.svh"

module mac_pe import systolic_pkg::*; (
    input  logic  clk,
    input  logic  clear,
    input  data_t in_a,
    input  data_t in_b,
    output data_t out_a,
    output data_t out_b,
    output data_t acc
);

    data_t a_q;
    data_t b_q;
    data_t prod;

    // Forwarding to the right and downward neighbours
    always_ff @(posedge clk) begin
        if (clear) begin
            out_a <= '0;
            out_b <= '0;
        end else begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    ////////////////////
    // MAC pipeline
    ////////////////////

    // Operand stage, product stage, accumulate stage
    // Only the low byte of the product is kept, so everything wraps mod 256
    always_ff @(posedge clk) begin
        if (clear) begin
            a_q  <= '0;
            b_q  <= '0;
            prod <= '0;
            acc  <= '0;
        end else begin
            a_q  <= in_a;
            b_q  <= in_b;
            prod <= a_q * b_q;
            acc  <= acc + prod;
        end
    end

endmodule

// File: design/pe_array.sv
`timescale 1ns/100ps
`include "systolic_config.svh"

module pe_array import systolic_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  data_vec_t                 feed_a,
    input  data_vec_t                 feed_b,
    output data_vec_t [`SYS_SIZE-1:0] results
);

    logic clear;

    // a_link[r][c] enters PE(r,c) from the left, b_link[r][c] from above
    // The last column of a_link and last row of b_link fall off the mesh
    data_t a_link [`SYS_SIZE][`SYS_SIZE+1];
    data_t b_link [`SYS_SIZE+1][`SYS_SIZE];

    // Accumulators start from zero for every job
    assign clear = reset || !start;

    for (genvar k = 0; k < `SYS_SIZE; k++) begin : g_edge
        assign a_link[k][0] = feed_a[k];
        assign b_link[0][k] = feed_b[k];
    end

    ////////////////////
    // PE mesh
    ////////////////////

    for (genvar r = 0; r < `SYS_SIZE; r++) begin : g_row
        for (genvar c = 0; c < `SYS_SIZE; c++) begin : g_col
            // Result of PE(r,c) is element r of column c
            mac_pe u_pe (
                .clk   (clk),
                .clear (clear),
                .in_a  (a_link[r][c]),
                .in_b  (b_link[r][c]),
                .out_a (a_link[r][c+1]),
                .out_b (b_link[r+1][c]),
                .acc   (results[c][r])
            );
        end
    end

endmodule

// File: design/operand_feeder.sv
`timescale 1ns/100ps
`include "systolic_config.svh"

module operand_feeder import systolic_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        fetch_active,
    input  mat_region_t region,
    input  data_vec_t   mem_data,
    output addr_t       mem_addr,
    output data_vec_t   feed
);

    // Bit 0 is set while an address is on the bus, later bits track the
    // request through the memory
    logic [`SYS_MEM_LATENCY:0] issued;
    logic                      word_valid;
    data_vec_t                 lane_word;

    ////////////////////
    // Address stepping
    ////////////////////

    // Outside the fetch window the address rests one stride below base
    always_ff @(posedge clk) begin
        if (reset || !start || !fetch_active) begin
            mem_addr <= region.base - addr_t'(region.stride);
        end else begin
            mem_addr <= mem_addr + addr_t'(region.stride);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !start) begin
            issued <= '0;
        end else begin
            issued <= {issued[`SYS_MEM_LATENCY-1:0], fetch_active};
        end
    end

    assign word_valid = issued[`SYS_MEM_LATENCY];

    // Anything the memory returns outside the window is treated as zero
    assign lane_word = word_valid ? mem_data : '0;

    ////////////////////
    // Systolic skew
    ////////////////////

    // Lane i passes through i registers, so the bank is triangular
    for (genvar i = 0; i < `SYS_SIZE; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign feed[i] = lane_word[i];
        end else begin : g_delay
            data_t chain [i];

            always_ff @(posedge clk) begin
                if (reset || !start) begin
                    for (int j = 0; j < i; j++) begin
                        chain[j] <= '0;
                    end
                end else begin
                    chain[0] <= lane_word[i];
                    for (int j = 1; j < i; j++) begin
                        chain[j] <= chain[j-1];
                    end
                end
            end

            assign feed[i] = chain[i-1];
        end
    end

endmodule

// File: design/matmul_sequencer.sv
`timescale 1ns/100ps
`include "systolic_config.svh"

module matmul_sequencer import systolic_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic fetch_active,
    output logic capture,
    output logic done
);

    seq_state_t state;
    cycle_t     cnt;

    // The count is zero on the first edge with start high, so the
    // fetch window covers counts 0 to N-1
    assign fetch_active = start && (state != SEQ_FINISHED) && (cnt < `SYS_SIZE);

    assign capture = (state == SEQ_RUN) && (cnt == cycle_t'(`SYS_CAPTURE_CYCLE));

    always_ff @(posedge clk) begin
        if (reset || !start) begin
            state <= SEQ_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    state <= SEQ_RUN;
                    cnt   <= cnt + 1'b1;
                end
                SEQ_RUN: begin
                    cnt <= cnt + 1'b1;
                    // Last column leaves the drain on this count
                    if (cnt == cycle_t'(`SYS_CAPTURE_CYCLE + `SYS_SIZE)) begin
                        done  <= 1'b1;
                        state <= SEQ_FINISHED;
                    end
                end
                SEQ_FINISHED: begin
                    // Counter holds here so that it never wraps into a second fetch
                    done <= 1'b0;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/result_drain.sv
`timescale 1ns/100ps
`include "systolic_config.svh"

module result_drain import systolic_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      capture,
    input  logic                      done,
    input  mat_region_t               region_c,
    input  data_vec_t [`SYS_SIZE-1:0] results,
    output addr_t                     c_addr,
    output data_vec_t                 c_data,
    output logic                      c_data_available
);

    // Column queue, entry 0 is the word on c_data
    data_vec_t [`SYS_SIZE-1:0] col_q;

    // Number of columns presented so far in this window
    logic [$clog2(`SYS_SIZE):0] col_cnt;

    assign c_data = col_q[0];

    ////////////////////
    // Capture and shift
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset || !start) begin
            col_q            <= '0;
            col_cnt          <= '0;
            c_data_available <= 1'b0;
            c_addr           <= region_c.base - addr_t'(region_c.stride);
        end else if (capture) begin
            // First column goes out right away at base
            col_q            <= results;
            col_cnt          <= 1'b1;
            c_data_available <= 1'b1;
            c_addr           <= c_addr + addr_t'(region_c.stride);
        end else if (done) begin
            // Rearm so the next job starts again at base
            c_addr <= region_c.base - addr_t'(region_c.stride);
        end else if (c_data_available) begin
            col_q <= {data_vec_t'('0), col_q[`SYS_SIZE-1:1]};
            if (col_cnt == `SYS_SIZE) begin
                col_cnt          <= '0;
                c_data_available <= 1'b0;
            end else begin
                col_cnt <= col_cnt + 1'b1;
                c_addr  <= c_addr + addr_t'(region_c.stride);
            end
        end
    end

endmodule

// File: design/matmul_4x4_systolic.sv
`timescale 1ns/100ps
`include "systolic_config.svh"

module matmul_4x4_systolic import systolic_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  mat_region_t region_a,
    input  mat_region_t region_b,
    input  mat_region_t region_c,
    input  data_vec_t   a_data,
    input  data_vec_t   b_data,
    output addr_t       a_addr,
    output addr_t       b_addr,
    output addr_t       c_addr,
    output data_vec_t   c_data,
    output logic        c_data_available,
    output logic        done
);

    logic fetch_active;
    logic capture;

    data_vec_t feed_a;
    data_vec_t feed_b;

    // Indexed by column of C
    data_vec_t [`SYS_SIZE-1:0] results;

    ////////////////////
    // Job control
    ////////////////////

    matmul_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .fetch_active (fetch_active),
        .capture      (capture),
        .done         (done)
    );

    ////////////////////
    // Operand fetch
    ////////////////////

    // A arrives column by column and feeds the rows of the mesh
    operand_feeder u_feed_a (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .fetch_active (fetch_active),
        .region       (region_a),
        .mem_data     (a_data),
        .mem_addr     (a_addr),
        .feed         (feed_a)
    );

    // B arrives row by row and feeds the columns of the mesh
    operand_feeder u_feed_b (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .fetch_active (fetch_active),
        .region       (region_b),
        .mem_data     (b_data),
        .mem_addr     (b_addr),
        .feed         (feed_b)
    );

    pe_array u_pe_array (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .feed_a  (feed_a),
        .feed_b  (feed_b),
        .results (results)
    );

    result_drain u_drain (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .capture          (capture),
        .done             (done),
        .region_c         (region_c),
        .results          (results),
        .c_addr           (c_addr),
        .c_data           (c_data),
        .c_data_available (c_data_available)
    );

endmodule

// File: testbench/tb_matmul_4x4_systolic.sv
`timescale 1ns/100ps
`include "systolic_config.svh"

module tb_matmul_4x4_systolic import systolic_pkg::*;;

    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 40;
    localparam int JOB_TIMEOUT     = `SYS_CAPTURE_CYCLE + 2 * `SYS_SIZE + 10;
    localparam int MEM_DEPTH       = 2 ** `SYS_AWIDTH;

    logic        clk;
    logic        reset;
    logic        start;
    mat_region_t region_a;
    mat_region_t region_b;
    mat_region_t region_c;
    data_vec_t   a_data = '0;
    data_vec_t   b_data = '0;
    addr_t       a_addr;
    addr_t       b_addr;
    addr_t       c_addr;
    data_vec_t   c_data;
    logic        c_data_available;
    logic        done;

    data_vec_t mem_a [MEM_DEPTH];
    data_vec_t mem_b [MEM_DEPTH];

    data_t mat_a [`SYS_SIZE][`SYS_SIZE];
    data_t mat_b [`SYS_SIZE][`SYS_SIZE];
    data_t ref_c [`SYS_SIZE][`SYS_SIZE];

    // Words seen on the C port, with their address and cycle stamp
    data_vec_t col_data_q [$];
    addr_t     col_addr_q [$];
    int        col_cycle_q [$];
    int        done_count = 0;
    logic      done_after_col = 1'b0;
    logic      avail_prev = 1'b0;
    int        cycle_no = 0;

    logic [31:0] lfsr_state = 32'hae9e;

    matmul_4x4_systolic DUT (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .region_a         (region_a),
        .region_b         (region_b),
        .region_c         (region_c),
        .a_data           (a_data),
        .b_data           (b_data),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .c_addr           (c_addr),
        .c_data           (c_data),
        .c_data_available (c_data_available),
        .done             (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Memory models and C collector
    ////////////////////

    // Both memories return the addressed word one cycle later
    always @(posedge clk) begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
    end

    always @(posedge clk) begin
        cycle_no++;
        if (c_data_available) begin
            col_data_q.push_back(c_data);
            col_addr_q.push_back(c_addr);
            col_cycle_q.push_back(cycle_no);
        end
        if (done) begin
            done_count++;
            done_after_col = avail_prev;
        end
        avail_prev = c_data_available;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the tests did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog timeout");
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic data_t random_byte();
        data_t value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic randomize_matrices();
        for (int r = 0; r < `SYS_SIZE; r++) begin
            for (int c = 0; c < `SYS_SIZE; c++) begin
                mat_a[r][c] = random_byte();
                mat_b[r][c] = random_byte();
            end
        end
    endtask

    // C[r][c] is the sum over k of A[r][k] * B[k][c], kept modulo 256
    task automatic compute_reference();
        int sum;
        for (int r = 0; r < `SYS_SIZE; r++) begin
            for (int c = 0; c < `SYS_SIZE; c++) begin
                sum = 0;
                for (int k = 0; k < `SYS_SIZE; k++) begin
                    sum += int'(mat_a[r][k]) * int'(mat_b[k][c]);
                end
                ref_c[r][c] = data_t'(sum % 256);
            end
        end
    endtask

    // Background depends on the full address, then A columns and B rows go on top
    task automatic load_memories(input mat_region_t ra, input mat_region_t rb);
        data_vec_t word;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_a[i] = {6'h2a, addr_t'(i), 6'h15, ~addr_t'(i)};
            mem_b[i] = {~addr_t'(i), 6'h33, addr_t'(i), 6'h0c};
        end
        for (int k = 0; k < `SYS_SIZE; k++) begin
            for (int i = 0; i < `SYS_SIZE; i++) begin
                word[i] = mat_a[i][k];
            end
            mem_a[addr_t'(ra.base + k * ra.stride)] = word;
            for (int j = 0; j < `SYS_SIZE; j++) begin
                word[j] = mat_b[k][j];
            end
            mem_b[addr_t'(rb.base + k * rb.stride)] = word;
        end
    endtask

    task automatic clear_collector();
        col_data_q.delete();
        col_addr_q.delete();
        col_cycle_q.delete();
        done_count = 0;
        done_after_col = 1'b0;
    endtask

    // Regions go out one edge ahead of start so the rest addresses follow them
    task automatic apply_regions(input mat_region_t ra, input mat_region_t rb,
                                 input mat_region_t rc);
        @(posedge clk);
        region_a <= ra;
        region_b <= rb;
        region_c <= rc;
    endtask

    task automatic run_job(input mat_region_t ra, input mat_region_t rb,
                           input mat_region_t rc);
        int waited;
        @(negedge clk);
        clear_collector();
        compute_reference();
        load_memories(ra, rb);
        apply_regions(ra, rb, rc);
        @(posedge clk);
        start <= 1'b1;
        for (waited = 0; waited < JOB_TIMEOUT && done_count == 0; waited++) begin
            @(negedge clk);
        end
        if (done_count == 0) begin
            $display("Timeout: done did not rise within %0d cycles of start", JOB_TIMEOUT);
            $display("STATUS: FAIL");
            $fatal(1, "Job timeout");
        end
        // Outputs must stay quiet while start is still high
        repeat (`SYS_SIZE) @(negedge clk);
        check_equal(col_data_q.size(), `SYS_SIZE, "number of C columns");
        check_equal(done_count, 1, "number of done pulses");
        check_equal(done_after_col, 1'b1, "done right after the last column");
        for (int k = 0; k < `SYS_SIZE; k++) begin
            check_equal(col_cycle_q[k] - col_cycle_q[0], k, "C window is contiguous");
            check_equal(col_addr_q[k], addr_t'(rc.base + k * rc.stride),
                        $sformatf("c_addr of column %0d", k));
            for (int r = 0; r < `SYS_SIZE; r++) begin
                check_equal(col_data_q[k][r], ref_c[r][k],
                            $sformatf("C[%0d][%0d]", r, k));
            end
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic idle_after_reset();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_equal(done, 1'b0, "done while idle");
            check_equal(c_data_available, 1'b0, "c_data_available while idle");
            check_equal(c_data, '0, "c_data while idle");
            check_equal(a_addr, addr_t'(region_a.base - region_a.stride), "a_addr at rest");
            check_equal(b_addr, addr_t'(region_b.base - region_b.stride), "b_addr at rest");
            check_equal(c_addr, addr_t'(region_c.base - region_c.stride), "c_addr at rest");
        end
    endtask

    task automatic identity_times_ramp();
        for (int r = 0; r < `SYS_SIZE; r++) begin
            for (int c = 0; c < `SYS_SIZE; c++) begin
                mat_a[r][c] = (r == c) ? 8'd1 : 8'd0;
                mat_b[r][c] = data_t'(r * `SYS_SIZE + c + 1);
            end
        end
        run_job('{base: 10'h010, stride: 8'd1}, '{base: 10'h040, stride: 8'd1},
                '{base: 10'h100, stride: 8'd1});
    endtask

    task automatic random_uneven_strides();
        randomize_matrices();
        run_job('{base: 10'h0a7, stride: 8'd3}, '{base: 10'h1f3, stride: 8'd5},
                '{base: 10'h2c1, stride: 8'd7});
    endtask

    // 200 * 200 * 4 is a multiple of 256
    task automatic wrap_around_sum();
        for (int r = 0; r < `SYS_SIZE; r++) begin
            for (int c = 0; c < `SYS_SIZE; c++) begin
                mat_a[r][c] = 8'd200;
                mat_b[r][c] = 8'd200;
            end
        end
        run_job('{base: 10'h000, stride: 8'd2}, '{base: 10'h3f0, stride: 8'd1},
                '{base: 10'h200, stride: 8'd4});
    endtask

    task automatic back_to_back_jobs();
        randomize_matrices();
        run_job('{base: 10'h031, stride: 8'd9}, '{base: 10'h155, stride: 8'd2},
                '{base: 10'h0e0, stride: 8'd3});
        randomize_matrices();
        run_job('{base: 10'h031, stride: 8'd9}, '{base: 10'h155, stride: 8'd2},
                '{base: 10'h0e0, stride: 8'd3});
    endtask

    task automatic abort_during_fetch();
        mat_region_t ra;
        mat_region_t rb;
        mat_region_t rc;
        ra = '{base: 10'h180, stride: 8'd6};
        rb = '{base: 10'h2a2, stride: 8'd11};
        rc = '{base: 10'h333, stride: 8'd5};
        randomize_matrices();
        @(negedge clk);
        clear_collector();
        load_memories(ra, rb);
        apply_regions(ra, rb, rc);
        @(posedge clk);
        start <= 1'b1;
        repeat (2) @(posedge clk);
        start <= 1'b0;
        repeat (20) @(negedge clk);
        check_equal(col_data_q.size(), 0, "C words after an abort");
        check_equal(done_count, 0, "done pulses after an abort");
        randomize_matrices();
        run_job(ra, rb, rc);
    endtask

    initial begin
        reset    <= 1'b1;
        start    <= 1'b0;
        region_a <= '{base: 10'h020, stride: 8'd2};
        region_b <= '{base: 10'h080, stride: 8'd1};
        region_c <= '{base: 10'h300, stride: 8'd4};
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        idle_after_reset();
        identity_times_ramp();
        random_uneven_strides();
        wrap_around_sum();
        back_to_back_jobs();
        abort_during_fetch();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: matmul_4x4_systolic.f
+incdir+design
design/systolic_pkg.sv
design/mac_pe.sv
design/pe_array.sv
design/operand_feeder.sv
design/matmul_sequencer.sv
design/result_drain.sv
design/matmul_4x4_systolic.sv
testbench/tb_matmul_4x4_systolic.sv
